/* Makefile */
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
LOG       ?= sim.log
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim.f */
+incdir+src
+incdir+sim
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_core.sv
sim/tb_rv_core.sv

/* sim/tb_rv_model.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I reference model, instruction encoders, program memory and LCG
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

localparam int PROG_WORDS = 64;

logic [`RV_XLEN-1:0] prog [PROG_WORDS];
logic [`RV_XLEN-1:0] mregs [`RV_NREGS];  // Model register file
logic [`RV_XLEN-1:0] mpc;                // Model pc, next fetch address
logic [31:0]         lcg_state = 32'd12690;
int                  pidx;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Opcode 0 is not decoded, so unused memory retires as a no-op
function automatic logic [`RV_XLEN-1:0] fill_word(input logic [`RV_XLEN-1:0] addr);
    return {addr[26:2], 7'h00};
endfunction

function automatic logic [`RV_XLEN-1:0] fetch_word(input logic [`RV_XLEN-1:0] addr);
    logic [`RV_XLEN-1:0] off;
    off = addr - `RV_RESET_PC;
    if (off < PROG_WORDS * 4) return prog[off[7:2]];
    return fill_word(addr);
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2, rs1,
                                       input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

task automatic clear_prog();
    for (int i = 0; i < PROG_WORDS; i++) begin
        prog[i] = fill_word(`RV_RESET_PC + (i << 2));
    end
    pidx = 0;
endtask

task automatic put_word(input logic [31:0] w);
    prog[pidx] = w;
    pidx++;
endtask

task automatic model_reset();
    for (int i = 0; i < `RV_NREGS; i++) begin
        mregs[i] = '0;
    end
    mpc = `RV_RESET_PC;
endtask

function automatic logic [`RV_XLEN-1:0] alu_ref(input rv_pkg::alu_op_e op,
                                                input logic [`RV_XLEN-1:0] a, b);
    case (op)
        rv_pkg::ALU_SUB:  return a - b;
        rv_pkg::ALU_SLL:  return a << b[4:0];
        rv_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        rv_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        rv_pkg::ALU_XOR:  return a ^ b;
        rv_pkg::ALU_SRL:  return a >> b[4:0];
        rv_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
        rv_pkg::ALU_OR:   return a | b;
        rv_pkg::ALU_AND:  return a & b;
        default:          return a + b;
    endcase
endfunction

// Executes the word at mpc and predicts its retire
task automatic model_step(output logic [4:0] rd, output logic we,
                          output logic [`RV_XLEN-1:0] wdata,
                          output rv_pkg::alu_op_e op, output logic is_alu);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] npc;
    logic        take;
    w      = fetch_word(mpc);
    rd     = w[11:7];
    a      = mregs[w[19:15]];
    b      = mregs[w[24:20]];
    imm_i  = {{20{w[31]}}, w[31:20]};
    npc    = mpc + 32'd4;
    we     = 1'b1;
    wdata  = npc;  // Link value for jumps
    op     = rv_pkg::ALU_ADD;
    is_alu = 1'b0;
    take   = 1'b0;
    case (w[6:0])
        7'b0110011, 7'b0010011: begin
            is_alu = 1'b1;
            if (w[6:0] == 7'b0010011) b = imm_i;
            case (w[14:12])
                3'd0: op = (w[5] && w[30]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                3'd1: op = rv_pkg::ALU_SLL;
                3'd2: op = rv_pkg::ALU_SLT;
                3'd3: op = rv_pkg::ALU_SLTU;
                3'd4: op = rv_pkg::ALU_XOR;
                3'd5: op = w[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'd6: op = rv_pkg::ALU_OR;
                default: op = rv_pkg::ALU_AND;
            endcase
            wdata = alu_ref(op, a, b);
        end
        7'b0110111: wdata = {w[31:12], 12'h000};        // LUI
        7'b0010111: wdata = mpc + {w[31:12], 12'h000};  // AUIPC
        7'b1101111: npc = mpc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        7'b1100111: npc = (a + imm_i) & ~32'd1;
        7'b1100011: begin
            we = 1'b0;
            case (w[14:12])
                3'd0: take = (a == b);
                3'd1: take = (a != b);
                3'd4: take = ($signed(a) < $signed(b));
                3'd5: take = ($signed(a) >= $signed(b));
                3'd6: take = (a < b);
                3'd7: take = (a >= b);
                default: take = 1'b0;
            endcase
            if (take) npc = mpc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        default: we = 1'b0;  // Unknown opcode
    endcase
    if (rd == 5'd0) we = 1'b0;
    if (we) mregs[rd] = wdata;
    mpc = npc;
endtask

`endif

/* sim/tb_rv_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the RV32I core: memory model, directed tests, retire checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module tb_rv_core;

    localparam int CLK_PERIOD    = 10;
    localparam int NUM_TESTS     = 6;
    localparam int TOTAL_RETIRES = 65;
    localparam int TIMEOUT_NS    = (TOTAL_RETIRES * 7 + NUM_TESTS * 12 + 200) * CLK_PERIOD;

    logic                 clk;
    logic                 reset;
    logic                 imem_valid;
    logic [`RV_XLEN-1:0]  imem_rdata;
    logic                 imem_req;
    logic [`RV_XLEN-1:0]  imem_addr;
    logic                 retire_valid;
    logic [`RV_XLEN-1:0]  retire_pc;
    logic [`RV_REG_W-1:0] retire_rd;
    logic                 retire_we;
    logic [`RV_XLEN-1:0]  retire_wdata;

    int                  errors;
    int                  checks;
    int                  lat;
    logic [`RV_XLEN-1:0] mem_addr;
    time                 valid_time;
    time                 retire_time;
    logic                retired;  // A retire seen since reset

    `include "tb_rv_model.svh"

    rv_core i_dut (
        .clk          (clk),
        .reset        (reset),
        .imem_valid   (imem_valid),
        .imem_rdata   (imem_rdata),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_we    (retire_we),
        .retire_wdata (retire_wdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_word(input string what, input logic [`RV_XLEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_dest(input logic [`RV_REG_W-1:0] got_rd, input logic got_we,
                              input logic [`RV_REG_W-1:0] exp_rd, input logic exp_we);
        checks++;
        if (got_rd !== exp_rd || got_we !== exp_we) begin
            errors++;
            $display("Fail at %0d ns: rd x%0d we %b, expected x%0d we %b",
                     $time, got_rd, got_we, exp_rd, exp_we);
        end
    endtask

    task automatic check_alu(input rv_pkg::alu_op_e op, input logic [`RV_XLEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s result %h, expected %h", $time, op.name(), got, exp);
        end
    endtask

    // Answers each request 0 to 3 cycles into the wait state
    always begin
        @(negedge clk);
        if (imem_req) begin
            mem_addr = imem_addr;
            lat      = (lcg_next() >> 16) % 4;
            repeat (lat + 1) @(negedge clk);
            imem_valid = 1'b1;
            imem_rdata = fetch_word(mem_addr);
            valid_time = $time;
            @(negedge clk);
            imem_valid = 1'b0;
        end
    end

    // Retire and fetch timing, fetch address against the model pc
    always @(negedge clk) begin
        if (reset) begin
            retired = 1'b0;
        end else begin
            if (retire_valid) begin
                if ($time != valid_time + CLK_PERIOD) begin
                    errors++;
                    $display("Retire at %0d ns did not come one cycle after imem_valid", $time);
                end
                retired     = 1'b1;
                retire_time = $time;
            end
            if (imem_req) begin
                if (retired && $time != retire_time + CLK_PERIOD) begin
                    errors++;
                    $display("imem_req at %0d ns did not come one cycle after retire", $time);
                end
                check_word("imem_addr", imem_addr, mpc);
            end
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (8) begin
            @(negedge clk);
            if (imem_req || retire_valid) begin
                errors++;
                $display("imem_req or retire_valid was high during reset at %0d ns", $time);
            end
        end
        model_reset();
        reset = 1'b0;
    endtask

    task automatic run_program(input string name, input int n);
        int                  err0;
        logic [4:0]          rd;
        logic                we;
        logic [`RV_XLEN-1:0] wd;
        logic [`RV_XLEN-1:0] pc_exp;
        rv_pkg::alu_op_e     op;
        logic                is_alu;
        err0 = errors;
        apply_reset();
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            while (!retire_valid) @(negedge clk);
            pc_exp = mpc;
            model_step(rd, we, wd, op, is_alu);
            check_word("retire_pc", retire_pc, pc_exp);
            check_dest(retire_rd, retire_we, rd, we);
            if (we && is_alu) check_alu(op, retire_wdata, wd);
            else if (we) check_word("retire_wdata", retire_wdata, wd);
        end
        $display("Test %s finished: %0d retires, %0d errors", name, n, errors - err0);
    endtask

    task automatic test_reset_first_fetch();
        clear_prog();
        put_word(i_type(12'd1, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OP_IMM));
        put_word(i_type(12'd1, 5'd1, 3'd0, 5'd1, rv_pkg::OPC_OP_IMM));
        run_program("reset_first_fetch", 2);
    endtask

    task automatic test_alu();
        clear_prog();
        put_word(i_type(12'hFF9, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OP_IMM));  // addi x1, x0, -7
        put_word(i_type(12'd3, 5'd0, 3'd0, 5'd2, rv_pkg::OPC_OP_IMM));
        put_word(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));                   // add
        put_word(r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd4));                   // sub
        put_word(r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd5));                   // sra, negative
        put_word(i_type(12'h41F, 5'd1, 3'd5, 5'd6, rv_pkg::OPC_OP_IMM));  // srai by 31
        put_word(i_type(12'h01F, 5'd2, 3'd1, 5'd7, rv_pkg::OPC_OP_IMM));  // slli by 31
        put_word(i_type(12'h01F, 5'd1, 3'd5, 5'd8, rv_pkg::OPC_OP_IMM));  // srli by 31
        put_word(r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd9));                   // slt
        put_word(r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd10));                  // sltu
        put_word(i_type(12'h0F0, 5'd1, 3'd4, 5'd11, rv_pkg::OPC_OP_IMM));
        put_word(r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd12));
        put_word(r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd13));
        put_word(i_type(12'hFFF, 5'd2, 3'd3, 5'd14, rv_pkg::OPC_OP_IMM));  // sltiu vs all ones
        put_word(r_type(7'h00, 5'd6, 5'd2, 3'd1, 5'd15));                  // sll by x6 = 31
        put_word(i_type(12'd5, 5'd1, 3'd0, 5'd0, rv_pkg::OPC_OP_IMM));    // Write to x0
        put_word(r_type(7'h00, 5'd2, 5'd0, 3'd0, 5'd16));                  // Reads x0 back
        put_word(r_type(7'h00, 5'd2, 5'd1, 3'd5, 5'd17));                  // srl
        run_program("alu", 18);
    endtask

    task automatic test_upper();
        clear_prog();
        put_word(u_type(20'h12345, 5'd1, rv_pkg::OPC_LUI));
        put_word(u_type(20'hFFFFF, 5'd2, rv_pkg::OPC_AUIPC));
        put_word(u_type(20'h00000, 5'd3, rv_pkg::OPC_AUIPC));
        run_program("upper_immediate", 3);
    endtask

    task automatic test_jumps();
        clear_prog();
        put_word(u_type(20'h80000, 5'd5, rv_pkg::OPC_LUI));                // Base address
        put_word(j_type(21'd8, 5'd1));
        put_word(i_type(12'd99, 5'd0, 3'd0, 5'd9, rv_pkg::OPC_OP_IMM));
        put_word(i_type(12'd21, 5'd5, 3'd0, 5'd2, rv_pkg::OPC_JALR));      // Odd target
        put_word(i_type(12'd98, 5'd0, 3'd0, 5'd9, rv_pkg::OPC_OP_IMM));
        put_word(i_type(12'd0, 5'd1, 3'd0, 5'd3, rv_pkg::OPC_OP_IMM));
        put_word(j_type(21'd8, 5'd0));                                     // No link
        put_word(i_type(12'd97, 5'd0, 3'd0, 5'd9, rv_pkg::OPC_OP_IMM));
        put_word(i_type(12'd1, 5'd5, 3'd0, 5'd4, rv_pkg::OPC_JALR));       // Back to start
        run_program("jumps", 7);
    endtask

    task automatic put_branch_pair(input logic [2:0] f3, input logic [4:0] rs1, rs2);
        put_word(b_type(13'd8, rs2, rs1, f3));
        put_word(i_type(12'd1, 5'd10, 3'd0, 5'd10, rv_pkg::OPC_OP_IMM));  // Skipped if taken
    endtask

    task automatic test_branches();
        clear_prog();
        put_word(i_type(12'hFFF, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OP_IMM));  // x1 = -1
        put_word(i_type(12'd1, 5'd0, 3'd0, 5'd2, rv_pkg::OPC_OP_IMM));
        put_word(i_type(12'd1, 5'd0, 3'd0, 5'd3, rv_pkg::OPC_OP_IMM));
        put_branch_pair(3'd0, 5'd2, 5'd3);
        put_branch_pair(3'd0, 5'd1, 5'd2);
        put_branch_pair(3'd1, 5'd1, 5'd2);
        put_branch_pair(3'd1, 5'd2, 5'd3);
        put_branch_pair(3'd4, 5'd1, 5'd2);  // Signed, -1 < 1
        put_branch_pair(3'd4, 5'd2, 5'd1);
        put_branch_pair(3'd5, 5'd2, 5'd1);
        put_branch_pair(3'd5, 5'd1, 5'd2);
        put_branch_pair(3'd6, 5'd2, 5'd1);  // Unsigned, x1 is large
        put_branch_pair(3'd6, 5'd1, 5'd2);
        put_branch_pair(3'd7, 5'd1, 5'd2);
        put_branch_pair(3'd7, 5'd2, 5'd1);
        run_program("branches", 21);
    endtask

    task automatic test_latency_unknown();
        clear_prog();
        put_word(i_type(12'd5, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OP_IMM));
        put_word(32'h0000_0F8B);  // Custom opcode with rd = x31
        put_word(i_type(12'd4, 5'd0, 3'd0, 5'd2, rv_pkg::OPC_OP_IMM));
        put_word(i_type(12'hFFF, 5'd2, 3'd0, 5'd2, rv_pkg::OPC_OP_IMM));  // Loop body
        put_word(b_type(13'h1FFC, 5'd0, 5'd2, 3'd1));
        run_program("latency_and_unknown", 14);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        imem_valid = 1'b0;
        imem_rdata = '0;
        errors     = 0;
        checks     = 0;
        valid_time = 0;
        retired    = 1'b0;
        test_reset_first_fetch();
        test_alu();
        test_upper();
        test_jumps();
        test_branches();
        test_latency_unknown();
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired, the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src/rv_config.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I core configuration: data width, register file size and reset PC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NREGS 32
`define RV_REG_W 5

// First fetch address after reset
`define RV_RESET_PC 32'h8000_0000

`endif

/* src/rv_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multi-cycle RV32I core top: fetch, decode, register file and execute
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_core (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    imem_valid,
    input  wire  [`RV_XLEN-1:0]    imem_rdata,
    output logic                   imem_req,
    output logic [`RV_XLEN-1:0]    imem_addr,
    output logic                   retire_valid,
    output logic [`RV_XLEN-1:0]    retire_pc,
    output logic [`RV_REG_W-1:0]   retire_rd,
    output logic                   retire_we,
    output logic [`RV_XLEN-1:0]    retire_wdata
);

    logic [`RV_XLEN-1:0]  inst;
    logic [`RV_XLEN-1:0]  pc;
    logic [`RV_XLEN-1:0]  next_pc;
    logic                 exec;
    logic [`RV_REG_W-1:0] rd;
    logic [`RV_REG_W-1:0] rs1;
    logic [`RV_REG_W-1:0] rs2;
    logic [`RV_XLEN-1:0]  imm;
    logic [2:0]           funct3;
    rv_pkg::opcode_e      opcode;
    rv_pkg::alu_op_e      alu_op;
    rv_pkg::wb_sel_e      wb_sel;
    logic [`RV_XLEN-1:0]  rs1_data;
    logic [`RV_XLEN-1:0]  rs2_data;
    logic [`RV_XLEN-1:0]  wb_data;
    logic                 wb_en;
    logic                 rf_we;

    assign rf_we = exec & wb_en;  // wb_en is already low for rd == x0

    rv_fetch i_fetch (
        .clk        (clk),
        .reset      (reset),
        .imem_valid (imem_valid),
        .imem_rdata (imem_rdata),
        .next_pc    (next_pc),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .inst       (inst),
        .pc         (pc),
        .exec       (exec)
    );

    rv_decode i_decode (
        .inst   (inst),
        .rd     (rd),
        .rs1    (rs1),
        .rs2    (rs2),
        .imm    (imm),
        .opcode (opcode),
        .alu_op (alu_op),
        .funct3 (funct3),
        .wb_sel (wb_sel)
    );

    rv_regfile i_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    rv_execute i_execute (
        .opcode   (opcode),
        .funct3   (funct3),
        .alu_op   (alu_op),
        .wb_sel   (wb_sel),
        .imm      (imm),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .next_pc  (next_pc),
        .wb_data  (wb_data),
        .wb_en    (wb_en)
    );

    // Retire port mirrors the exec cycle
    assign retire_valid = exec;
    assign retire_pc    = pc;
    assign retire_rd    = rd;
    assign retire_we    = rf_we;
    assign retire_wdata = wb_data;

endmodule

`default_nettype wire

/* src/rv_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoder: instruction fields, immediate, ALU operation, writeback source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_decode (
    input  wire  [`RV_XLEN-1:0]  inst,
    output logic [`RV_REG_W-1:0] rd,
    output logic [`RV_REG_W-1:0] rs1,
    output logic [`RV_REG_W-1:0] rs2,
    output logic [`RV_XLEN-1:0]  imm,
    output rv_pkg::opcode_e      opcode,
    output rv_pkg::alu_op_e      alu_op,
    output logic [2:0]           funct3,
    output rv_pkg::wb_sel_e      wb_sel
);

    rv_pkg::inst_fmt_e fmt;
    logic              alt_op;  // funct7 bit 5, selects SUB and SRA

    assign opcode = rv_pkg::opcode_e'(inst[6:0]);
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign alt_op = inst[30];

    always_comb begin
        case (opcode)
            rv_pkg::OPC_OP:                     fmt = rv_pkg::FMT_R;
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_JALR: fmt = rv_pkg::FMT_I;
            rv_pkg::OPC_BRANCH:                 fmt = rv_pkg::FMT_B;
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: fmt = rv_pkg::FMT_U;
            rv_pkg::OPC_JAL:                    fmt = rv_pkg::FMT_J;
            default:                            fmt = rv_pkg::FMT_NONE;
        endcase
    end

    // Sign-extended immediates
    always_comb begin
        case (fmt)
            rv_pkg::FMT_I: imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::FMT_B: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_pkg::FMT_U: imm = {inst[31:12], 12'b0};
            rv_pkg::FMT_J: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:       imm = '0;  // R format and unknown opcodes
        endcase
    end

    always_comb begin
        alu_op = rv_pkg::ALU_ADD;  // Address arithmetic for jumps and branches
        if (opcode == rv_pkg::OPC_OP || opcode == rv_pkg::OPC_OP_IMM) begin
            case (funct3)
                3'b000: begin
                    if (fmt == rv_pkg::FMT_R && alt_op) alu_op = rv_pkg::ALU_SUB;
                end
                3'b001:  alu_op = rv_pkg::ALU_SLL;
                3'b010:  alu_op = rv_pkg::ALU_SLT;
                3'b011:  alu_op = rv_pkg::ALU_SLTU;
                3'b100:  alu_op = rv_pkg::ALU_XOR;
                3'b101:  alu_op = alt_op ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110:  alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

    // No writeback for x0, so the enable downstream already covers rd
    always_comb begin
        case (opcode)
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM,
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: wb_sel = rv_pkg::WB_ALU;
            rv_pkg::OPC_JAL, rv_pkg::OPC_JALR:  wb_sel = rv_pkg::WB_PC4;
            default:                            wb_sel = rv_pkg::WB_NONE;
        endcase
        if (rd == '0) wb_sel = rv_pkg::WB_NONE;
    end

endmodule

`default_nettype wire

/* src/rv_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage: operand select, ALU, branch compare, next PC and writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_execute (
    input  var rv_pkg::opcode_e    opcode,
    input  wire  [2:0]             funct3,
    input  var rv_pkg::alu_op_e    alu_op,
    input  var rv_pkg::wb_sel_e    wb_sel,
    input  wire  [`RV_XLEN-1:0]    imm,
    input  wire  [`RV_XLEN-1:0]    pc,
    input  wire  [`RV_XLEN-1:0]    rs1_data,
    input  wire  [`RV_XLEN-1:0]    rs2_data,
    output logic [`RV_XLEN-1:0]    next_pc,
    output logic [`RV_XLEN-1:0]    wb_data,
    output logic                   wb_en
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [4:0]          shamt;
    logic                taken;

    assign pc_plus4 = pc + 'd4;

    // Operand A: zero for LUI, pc for pc-relative forms
    always_comb begin
        case (opcode)
            rv_pkg::OPC_LUI:                     op_a = '0;
            rv_pkg::OPC_AUIPC, rv_pkg::OPC_JAL,
            rv_pkg::OPC_BRANCH:                  op_a = pc;
            default:                             op_a = rs1_data;
        endcase
    end

    assign op_b  = (opcode == rv_pkg::OPC_OP) ? rs2_data : imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_SUB:  alu_res = op_a - op_b;
            rv_pkg::ALU_SLL:  alu_res = op_a << shamt;
            rv_pkg::ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            rv_pkg::ALU_SRL:  alu_res = op_a >> shamt;
            rv_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> shamt;  // Keeps the sign bit
            rv_pkg::ALU_OR:   alu_res = op_a | op_b;
            rv_pkg::ALU_AND:  alu_res = op_a & op_b;
            default:          alu_res = op_a + op_b;
        endcase
    end

    // Branch condition on the raw register values
    always_comb begin
        case (funct3)
            3'b000:  taken = (rs1_data == rs2_data);                  // BEQ
            3'b001:  taken = (rs1_data != rs2_data);                  // BNE
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));  // BLT
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data)); // BGE
            3'b110:  taken = (rs1_data < rs2_data);                   // BLTU
            3'b111:  taken = (rs1_data >= rs2_data);                  // BGEU
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        next_pc = pc_plus4;  // Also the no-op path for unknown opcodes
        if (opcode == rv_pkg::OPC_JAL || (opcode == rv_pkg::OPC_BRANCH && taken)) begin
            next_pc = alu_res;
        end else if (opcode == rv_pkg::OPC_JALR) begin
            next_pc = {alu_res[`RV_XLEN-1:1], 1'b0};
        end
    end

    assign wb_data = (wb_sel == rv_pkg::WB_PC4) ? pc_plus4 : alu_res;
    assign wb_en   = (wb_sel != rv_pkg::WB_NONE);

endmodule

`default_nettype wire

/* src/rv_fetch.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch unit: PC register, request/wait/exec sequencer, instruction latch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_fetch (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    imem_valid,
    input  wire  [`RV_XLEN-1:0]    imem_rdata,
    input  wire  [`RV_XLEN-1:0]    next_pc,
    output logic                   imem_req,
    output logic [`RV_XLEN-1:0]    imem_addr,
    output logic [`RV_XLEN-1:0]    inst,
    output logic [`RV_XLEN-1:0]    pc,
    output logic                   exec
);

    typedef enum logic [1:0] {
        REQUEST,
        WAIT,
        EXEC
    } state_e;

    state_e state;
    logic   run;  // Low only in the cycle reset is held

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= REQUEST;
            run   <= 1'b0;
            pc    <= `RV_RESET_PC;
        end else begin
            run <= 1'b1;
            case (state)
                REQUEST: if (run) state <= WAIT;
                WAIT:    if (imem_valid) state <= EXEC;
                EXEC: begin
                    state <= REQUEST;
                    pc    <= next_pc;  // Commit the resolved target
                end
                default: state <= REQUEST;
            endcase
        end
    end

    // Instruction latch
    always_ff @(posedge clk) begin
        if (state == WAIT && imem_valid) begin
            inst <= imem_rdata;
        end
    end

    assign imem_req  = (state == REQUEST) && run;  // One-cycle pulse
    assign imem_addr = pc;                         // Held until the response
    assign exec      = (state == EXEC);

    // Memory must not answer without an outstanding request
    a_valid_only_in_wait: assert property (
        @(posedge clk) disable iff (reset) imem_valid |-> state == WAIT
    );

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I core types: opcodes, formats, ALU operations, writeback source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rv_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // Register-register ALU
        OPC_OP_IMM = 7'b0010011,  // Register-immediate ALU
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // Instruction format, selects the immediate layout
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE  // No immediate
    } inst_fmt_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Writeback source
    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_PC4  // Link address
    } wb_sel_e;

endpackage

`default_nettype wire

/* src/rv_regfile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file: x1..x31 writable, x0 hardwired to zero, 2R1W
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_regfile (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    we,
    input  wire  [`RV_REG_W-1:0]   waddr,
    input  wire  [`RV_REG_W-1:0]   raddr1,
    input  wire  [`RV_REG_W-1:0]   raddr2,
    input  wire  [`RV_XLEN-1:0]    wdata,
    output logic [`RV_XLEN-1:0]    rdata1,
    output logic [`RV_XLEN-1:0]    rdata2
);

    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];  // No storage for x0

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational reads
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // The decoder already drops writes aimed at x0
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (reset) we |-> waddr != '0
    );

endmodule

`default_nettype wire
